//--- include/lift_settings.svh
`ifndef LIFT_SETTINGS_SVH
`define LIFT_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Building size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LIFT_FLOORS 6 // Floors 0 to 5.
`define LIFT_FLOOR_W 3 // Bits for a floor number.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hall-call buttons
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// No up button on the top floor and no down button on the ground floor.
`define LIFT_HALL_UP_LO 0
`define LIFT_HALL_UP_HI 4
`define LIFT_HALL_DN_LO 1
`define LIFT_HALL_DN_HI 5

`endif

//--- rtl/liftStatePkg.sv
`include "lift_settings.svh"

package liftStatePkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Car state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [`LIFT_FLOOR_W-1:0] floorNumT;

	typedef enum logic {
		dirUp = 1'b0,
		dirDown = 1'b1
	} dirT;

	typedef enum logic [1:0] {
		phStopped = 2'd0, // Door closed, car parked.
		phDoorOpen = 2'd1,
		phMoving = 2'd2 // Between floors.
	} phaseT;

	localparam floorNumT groundFloor = '0;
	localparam floorNumT topFloor = floorNumT'(`LIFT_FLOORS - 1);

endpackage

//--- rtl/liftCallPkg.sv
`include "lift_settings.svh"

package liftCallPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Per-floor vectors
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bit n belongs to floor n. Used for car calls, both hall-call
	// directions and the landing sensors.
	typedef logic [`LIFT_FLOORS-1:0] floorMaskT;

	localparam floorMaskT noFloors = '0;

endpackage

//--- rtl/callStatusIf.sv
`timescale 1ns/10ps

interface callStatusIf import liftStatePkg::*; ();

	floorNumT probeFloor; // Floor the calls are scanned against.
	dirT dir; // Direction of travel.

	logic callHere; // Any call at the probe floor.
	logic callHereDir; // Call at the probe floor for this direction.
	logic callAbove;
	logic callBelow;

	modport ctrl (
		output probeFloor,
		output dir,
		input callHere,
		input callHereDir,
		input callAbove,
		input callBelow
	);

	modport eval (
		input probeFloor,
		input dir,
		output callHere,
		output callHereDir,
		output callAbove,
		output callBelow
	);

endinterface

//--- rtl/callEvaluator.sv
`timescale 1ns/10ps

`include "lift_settings.svh"

module callEvaluator import liftStatePkg::*, liftCallPkg::*; (
	input floorMaskT carCall,
	input floorMaskT hallUp,
	input floorMaskT hallDown,
	callStatusIf.eval status
);

	floorMaskT allCalls; // Every call, whatever its source.
	floorMaskT dirCalls; // Calls that want the current direction.
	floorMaskT hereMask;
	floorMaskT aboveMask;
	floorMaskT belowMask;
	logic atEndFloor;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Call merge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign allCalls = carCall | hallUp | hallDown;

	// A car call always counts, a hall call only for its own direction.
	assign dirCalls = (status.dir == dirUp) ? (carCall | hallUp) : (carCall | hallDown);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Floor masks relative to the probe floor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		hereMask = noFloors;
		aboveMask = noFloors;
		belowMask = noFloors;
		for (int i = 0; i < `LIFT_FLOORS; i++) begin
			if (floorNumT'(i) == status.probeFloor) begin
				hereMask[i] = 1'b1;
			end
			if (floorNumT'(i) > status.probeFloor) begin
				aboveMask[i] = 1'b1; // Strictly above.
			end
			if (floorNumT'(i) < status.probeFloor) begin
				belowMask[i] = 1'b1; // Strictly below.
			end
		end
	end

	assign atEndFloor = (status.probeFloor == groundFloor) ||
		(status.probeFloor == topFloor);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Summary levels
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign status.callHere = |(allCalls & hereMask);

	// The car turns at an end floor, so any call there is taken.
	always_comb begin
		if (atEndFloor) begin
			status.callHereDir = |(allCalls & hereMask);
		end else begin
			status.callHereDir = |(dirCalls & hereMask);
		end
	end

	assign status.callAbove = |(allCalls & aboveMask);
	assign status.callBelow = |(allCalls & belowMask);

endmodule

//--- rtl/carController.sv
`timescale 1ns/10ps

module carController import liftStatePkg::*, liftCallPkg::*; (
	input logic clk,
	input logic rstN,
	input logic emergency,
	input logic passengerIn,
	input floorMaskT sensor,
	callStatusIf.ctrl status,
	output logic moveUp,
	output logic moveDown,
	output logic openDoor,
	output logic closeDoor,
	output logic stop,
	output floorNumT lcd
);

	floorNumT floorQ; // Last floor the car stood at or passed.
	floorNumT floorD;
	dirT dirQ;
	dirT dirD;
	phaseT phaseQ;
	phaseT phaseD;

	floorNumT nextFloor; // Next landing in the direction of travel.
	dirT otherDir;
	logic callAhead;
	logic callBehind;
	logic arrived;
	logic atEndFloor;
	logic stopHere;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Probe for the call evaluator
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (dirQ == dirUp) begin
			nextFloor = floorQ + 1'b1;
			otherDir = dirDown;
		end else begin
			nextFloor = floorQ - 1'b1;
			otherDir = dirUp;
		end
	end

	// While moving, the calls are judged at the landing being approached.
	assign status.probeFloor = (phaseQ == phMoving) ? nextFloor : floorQ;
	assign status.dir = dirQ;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decisions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign callAhead = (dirQ == dirUp) ? status.callAbove : status.callBelow;
	assign callBehind = (dirQ == dirUp) ? status.callBelow : status.callAbove;

	assign arrived = sensor[status.probeFloor]; // Landing sensor of the probe floor.

	assign atEndFloor = (status.probeFloor == groundFloor) ||
		(status.probeFloor == topFloor);

	// Reasons to halt at the landing being reached.
	assign stopHere = emergency || status.callHereDir || atEndFloor || !callAhead;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		floorD = floorQ;
		dirD = dirQ;
		phaseD = phaseQ;

		case (phaseQ)
			phStopped: begin
				if (emergency || status.callHere) begin
					phaseD = phDoorOpen; // Serve this floor first.
				end else if (callAhead) begin
					phaseD = phMoving;
				end else if (callBehind) begin
					dirD = otherDir; // Nothing ahead, so turn round.
					phaseD = phMoving;
				end
			end

			phDoorOpen: begin
				// Emergency keeps the door open whatever the passenger does.
				if (!emergency && passengerIn) begin
					phaseD = phStopped;
				end
			end

			phMoving: begin
				if (arrived) begin
					floorD = nextFloor;
					if (stopHere) begin
						phaseD = phStopped;
					end
				end
			end

			default: begin
				phaseD = phaseQ;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			floorQ <= groundFloor;
			dirQ <= dirUp;
			phaseQ <= phStopped;
		end else begin
			floorQ <= floorD;
			dirQ <= dirD;
			phaseQ <= phaseD;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign moveUp = (dirQ == dirUp);
	assign moveDown = (dirQ == dirDown);

	assign openDoor = (phaseQ == phDoorOpen);
	assign closeDoor = !openDoor;

	assign stop = (phaseQ != phMoving); // Parked or door open.

	// Shows the departure floor until the next landing is reached.
	assign lcd = floorQ;

endmodule

//--- rtl/liftController.sv
`timescale 1ns/10ps

`include "lift_settings.svh"

module liftController import liftStatePkg::*, liftCallPkg::*; (
	input logic clk,
	input logic rstN,
	input logic emergency,
	input logic passengerIn,
	input floorMaskT sensor,
	input floorMaskT carCall,
	input logic [`LIFT_HALL_UP_HI:`LIFT_HALL_UP_LO] hallCallUp,
	input logic [`LIFT_HALL_DN_HI:`LIFT_HALL_DN_LO] hallCallDown,
	output logic moveUp,
	output logic moveDown,
	output logic openDoor,
	output logic closeDoor,
	output logic stop,
	output floorNumT lcd
);

	floorMaskT hallUpMask;
	floorMaskT hallDownMask;

	callStatusIf callStatus ();

	// Floors without a button read as no call.
	always_comb begin
		hallUpMask = noFloors;
		hallDownMask = noFloors;
		hallUpMask[`LIFT_HALL_UP_HI:`LIFT_HALL_UP_LO] = hallCallUp;
		hallDownMask[`LIFT_HALL_DN_HI:`LIFT_HALL_DN_LO] = hallCallDown;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Call scan and car FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	callEvaluator u_callEvaluator (
		.carCall (carCall),
		.hallUp (hallUpMask),
		.hallDown (hallDownMask),
		.status (callStatus.eval)
	);

	carController u_carController (
		.clk (clk),
		.rstN (rstN),
		.emergency (emergency),
		.passengerIn (passengerIn),
		.sensor (sensor),
		.status (callStatus.ctrl),
		.moveUp (moveUp),
		.moveDown (moveDown),
		.openDoor (openDoor),
		.closeDoor (closeDoor),
		.stop (stop),
		.lcd (lcd)
	);

endmodule

//--- sim/liftController_checker.sv
`timescale 1ns/10ps

`include "lift_settings.svh"

module liftControllerChecker (
	input logic clk,
	input logic rstN,
	input logic emergency,
	input logic moveUp,
	input logic moveDown,
	input logic openDoor,
	input logic closeDoor,
	input logic stop,
	input logic [`LIFT_FLOOR_W-1:0] lcd
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output decode rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	doorComplement: assert property (@(posedge clk) disable iff (!rstN)
		openDoor == !closeDoor)
		else $error("openDoor and closeDoor are not complementary");

	dirComplement: assert property (@(posedge clk) disable iff (!rstN)
		moveUp == !moveDown)
		else $error("moveUp and moveDown are not complementary");

	// The door never opens while the car travels.
	doorOnlyWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
		openDoor |-> stop)
		else $error("openDoor is high while the car is moving");

	lcdInRange: assert property (@(posedge clk) disable iff (!rstN)
		int'(lcd) < `LIFT_FLOORS)
		else $error("lcd shows a floor outside the building");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Emergency
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	emergencyHoldsDoor: assert property (@(posedge clk) disable iff (!rstN)
		(emergency && openDoor) |=> openDoor)
		else $error("door closed while emergency was held");

endmodule

//--- sim/liftControllerTb.sv
`timescale 1ns/10ps

`include "lift_settings.svh"

module liftControllerTb import liftCallPkg::*; ();

	localparam int numRows = 5;
	localparam int watchdogNs = numRows * `LIFT_FLOORS * 6 * 10 + 1000; // Margin covers reset.

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic emergency = 1'b0;
	logic passengerIn = 1'b0;
	floorMaskT sensor;
	floorMaskT carCall = noFloors;
	logic [`LIFT_HALL_UP_HI:`LIFT_HALL_UP_LO] hallCallUp = '0;
	logic [`LIFT_HALL_DN_HI:`LIFT_HALL_DN_LO] hallCallDown = '0;
	logic moveUp;
	logic moveDown;
	logic openDoor;
	logic closeDoor;
	logic stop;
	logic [`LIFT_FLOOR_W-1:0] lcd;

	// Scenario table, one entry per row.
	string rowName [numRows];
	floorMaskT rowCarCall [numRows];
	floorMaskT rowHallUp [numRows];
	floorMaskT rowHallDown [numRows];
	logic rowEmergency [numRows];
	int rowOpenFloor [numRows];
	bit rowHoldDoor [numRows];

	int travelDelays [64];
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;

	// Car position model state.
	logic [`LIFT_FLOOR_W-1:0] carPos = '0;
	logic betweenFloors = 1'b0;
	int travelLeft;
	logic [5:0] delayIdx;

	liftController u_liftController (
		.clk (clk),
		.rstN (rstN),
		.emergency (emergency),
		.passengerIn (passengerIn),
		.sensor (sensor),
		.carCall (carCall),
		.hallCallUp (hallCallUp),
		.hallCallDown (hallCallDown),
		.moveUp (moveUp),
		.moveDown (moveDown),
		.openDoor (openDoor),
		.closeDoor (closeDoor),
		.stop (stop),
		.lcd (lcd)
	);

	bind liftController liftControllerChecker u_liftControllerChecker (
		.clk (clk),
		.rstN (rstN),
		.emergency (emergency),
		.moveUp (moveUp),
		.moveDown (moveDown),
		.openDoor (openDoor),
		.closeDoor (closeDoor),
		.stop (stop),
		.lcd (lcd)
	);

	always #5 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Car position model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk or negedge rstN) begin
		if (!rstN) begin
			carPos <= '0;
			betweenFloors <= 1'b0;
			travelLeft <= 0;
			delayIdx <= '0;
		end else if (betweenFloors) begin
			if (travelLeft <= 1) begin
				carPos <= moveUp ? carPos + 1'b1 : carPos - 1'b1; // Next landing reached.
				betweenFloors <= 1'b0;
			end else begin
				travelLeft <= travelLeft - 1;
			end
		end else if (!stop) begin
			betweenFloors <= 1'b1; // Car leaves the landing.
			travelLeft <= travelDelays[delayIdx];
			delayIdx <= delayIdx + 1'b1;
		end
	end

	always_comb begin
		sensor = noFloors;
		if (!betweenFloors) begin
			sensor[carPos] = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reportMismatch(input string testName, input string what,
		input int expected, input int actual);
		$display("error %s %s: expected %0d, actual %0d", testName, what, expected, actual);
		errorCount++;
	endtask

	task automatic reportProblem(input string testName, input string text);
		$display("%s: %s", testName, text);
		errorCount++;
	endtask

	task automatic closeTest(input string testName, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			$display("%s: ok", testName);
			passCount++;
		end else begin
			$display("%s: FAILED", testName);
			failCount++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scenario table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic setRow(input int idx, input string name, input floorMaskT cc,
		input floorMaskT hu, input floorMaskT hd, input logic emg, input int openFloor,
		input bit hold);
		rowName[idx] = name;
		rowCarCall[idx] = cc;
		rowHallUp[idx] = hu;
		rowHallDown[idx] = hd;
		rowEmergency[idx] = emg;
		rowOpenFloor[idx] = openFloor;
		rowHoldDoor[idx] = hold;
	endtask

	task automatic loadTable();
		// Row  name               carCall    hallUp     hallDown   emg   open hold
		setRow(0, "carCallUpTo4", 6'b010000, 6'b000000, 6'b000000, 1'b0, 4, 1'b0);
		setRow(1, "carCallDownTo0", 6'b000001, 6'b000000, 6'b000000, 1'b0, 0, 1'b0);
		setRow(2, "passHallDown2", 6'b100000, 6'b000000, 6'b000100, 1'b0, 5, 1'b0);
		setRow(3, "carCallDownTo1", 6'b000010, 6'b000000, 6'b000000, 1'b0, 1, 1'b0);
		setRow(4, "emergencyHold", 6'b000000, 6'b000000, 6'b000000, 1'b1, 1, 1'b1);
	endtask

	task automatic runRow(input int idx);
		int errorsBefore;
		int startFloor;
		int prevLcd;
		int step;
		bit departed;
		bit dirReported;
		errorsBefore = errorCount;
		startFloor = int'(lcd);
		prevLcd = startFloor;
		departed = 1'b0;
		dirReported = 1'b0;
		if (rowOpenFloor[idx] > startFloor) begin
			step = 1;
		end else if (rowOpenFloor[idx] < startFloor) begin
			step = -1;
		end else begin
			step = 0;
		end

		carCall = rowCarCall[idx];
		hallCallUp = rowHallUp[idx][`LIFT_HALL_UP_HI:`LIFT_HALL_UP_LO];
		hallCallDown = rowHallDown[idx][`LIFT_HALL_DN_HI:`LIFT_HALL_DN_LO];
		emergency = rowEmergency[idx];

		while (!openDoor) begin
			@(negedge clk);
			if (!stop) begin
				departed = 1'b1;
			end
			if (!stop && step != 0 && !dirReported) begin
				if (moveUp != (step > 0)) begin
					reportMismatch(rowName[idx], "moveUp", int'(step > 0), int'(moveUp));
					dirReported = 1'b1;
				end
				if (moveDown != (step < 0)) begin
					reportMismatch(rowName[idx], "moveDown", int'(step < 0), int'(moveDown));
					dirReported = 1'b1;
				end
			end
			if (int'(lcd) != prevLcd) begin
				if (int'(lcd) != prevLcd + step) begin
					reportMismatch(rowName[idx], "lcd step", prevLcd + step, int'(lcd));
				end
				prevLcd = int'(lcd);
			end
			if (departed && stop && !openDoor && int'(lcd) != rowOpenFloor[idx]) begin
				reportProblem(rowName[idx], "car stopped before the expected floor");
			end
		end

		if (int'(lcd) != rowOpenFloor[idx]) begin
			reportMismatch(rowName[idx], "lcd", rowOpenFloor[idx], int'(lcd));
		end
		if (step != 0 && !departed) begin
			reportProblem(rowName[idx], "door opened but the car never moved");
		end

		if (rowHoldDoor[idx]) begin
			passengerIn = 1'b1; // Passenger enters while emergency is held.
			@(negedge clk);
			passengerIn = 1'b0;
			if (!openDoor) begin
				reportMismatch(rowName[idx], "openDoor held", 1, int'(openDoor));
			end
		end

		emergency = 1'b0;
		carCall = noFloors;
		hallCallUp = '0;
		hallCallDown = '0;
		passengerIn = 1'b1;
		@(negedge clk);
		passengerIn = 1'b0;
		if (!closeDoor) begin
			reportMismatch(rowName[idx], "closeDoor", 1, int'(closeDoor));
		end
		@(negedge clk);
		closeTest(rowName[idx], errorsBefore);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int errorsBefore;
		void'($urandom(24159));
		for (int i = 0; i < 64; i++) begin
			travelDelays[i] = 2 + int'($urandom % 5); // 2 to 6 cycles per floor.
		end
		loadTable();

		repeat (3) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		errorsBefore = errorCount;
		if (stop !== 1'b1) reportMismatch("resetState", "stop", 1, int'(stop));
		if (moveUp !== 1'b1) reportMismatch("resetState", "moveUp", 1, int'(moveUp));
		if (closeDoor !== 1'b1) reportMismatch("resetState", "closeDoor", 1, int'(closeDoor));
		if (openDoor !== 1'b0) reportMismatch("resetState", "openDoor", 0, int'(openDoor));
		if (lcd !== '0) reportMismatch("resetState", "lcd", 0, int'(lcd));
		closeTest("resetState", errorsBefore);

		for (int r = 0; r < numRows; r++) begin
			runRow(r);
		end

		$display("%0d tests: %0d passed, %0d failed, %0d errors", passCount + failCount,
			passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: the run did not finish within %0d ns.", watchdogNs);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
rtl/liftStatePkg.sv
rtl/liftCallPkg.sv
rtl/callStatusIf.sv
rtl/callEvaluator.sv
rtl/carController.sv
rtl/liftController.sv
sim/liftController_checker.sv
sim/liftControllerTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the lift controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module liftControllerTb -Mdir obj_dir

output=$(./obj_dir/VliftControllerTb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
else
	exit 1
fi
